// File: src.f
logic/bridge_pkg.sv
logic/sram_if.sv
logic/sram_port_slot.sv
logic/bridge_arbiter.sv
logic/axi_read_channel.sv
logic/axi_write_channel.sv
logic/sram_axi_bridge.sv
dv/axi_mem_model.sv
dv/tb_sram_axi_bridge.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_sram_axi_bridge -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
grep -q "=== PASS ===" sim.log

// File: dv/tb_sram_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sram_axi_bridge
    import bridge_pkg::*;
();
    typedef struct packed {
        logic [7:0] grp;
        port_t      port;
        logic       wr;
        addr_t      addr;
        size_t      size;
        strb_t      strb;
        word_t      wdata;
        word_t      exp;
    } op_t;

    logic clk = 1'b0;
    logic reset;

    logic inst_sram_req, inst_sram_wr, inst_sram_addr_ok, inst_sram_data_ok;
    size_t inst_sram_size;
    addr_t inst_sram_addr;
    strb_t inst_sram_wstrb;
    word_t inst_sram_wdata, inst_sram_rdata;
    logic data_sram_req, data_sram_wr, data_sram_addr_ok, data_sram_data_ok;
    size_t data_sram_size;
    addr_t data_sram_addr;
    strb_t data_sram_wstrb;
    word_t data_sram_wdata, data_sram_rdata;

    axi_id_t arid, rid, awid, wid, bid;
    addr_t araddr, awaddr;
    logic [7:0] arlen, awlen;
    logic [2:0] arsize, arprot, awsize, awprot;
    logic [1:0] arburst, arlock, awburst, awlock;
    logic [3:0] arcache, awcache;
    logic arvalid, arready, rvalid, rready, awvalid, awready;
    logic wvalid, wready, wlast, bvalid, bready;
    word_t rdata, wdata;
    strb_t wstrb;

    op_t        ops [$];
    logic [7:0] ref_mem [addr_t];
    int         open_cnt [NUM_PORTS];
    int         cur_idx [NUM_PORTS];
    axi_id_t    rid_prev, bid_prev, wid_prev;
    int         cycles = 0;
    int         limit = 1000;
    int         i, j;

    sram_axi_bridge sram_axi_bridge_i (.*);

    axi_mem_model mem_model (
        .clk(clk), .reset(reset),
        .arid(arid), .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rid(rid), .rdata(rdata), .rvalid(rvalid), .rready(rready),
        .awid(awid), .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bid(bid), .bvalid(bvalid), .bready(bready)
    );

    always #20 clk = !clk;

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_strb(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_attr(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_id(input string name, input port_t got, input port_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_resp(input string name, input axi_id_t got, input axi_id_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // single-beat INCR, unlocked, normal access for the port's open request
    task automatic audit_addr_beat(input string ch, input logic wr, input axi_id_t id,
                                   input addr_t addr, input logic [2:0] size,
                                   input logic [7:0] len, input logic [1:0] burst,
                                   input logic [1:0] lock, input logic [3:0] cache,
                                   input logic [2:0] prot);
        op_t op;
        op = ops[cur_idx[id[0]]];
        check_bit({ch, " request wr"}, op.wr, wr);
        check_addr({ch, "addr"}, addr, op.addr);
        check_attr({ch, "size"}, 8'(size), 8'(op.size));
        check_attr({ch, "len"}, len, 8'h00);
        check_attr({ch, "burst"}, 8'(burst), 8'h01);
        check_attr({ch, "lock"}, 8'(lock), 8'h00);
        check_attr({ch, "cache"}, 8'(cache), 8'h00);
        check_attr({ch, "prot"}, 8'(prot), 8'h00);
    endtask

    function automatic logic [7:0] expected_fill(input addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
    endfunction

    function automatic void add_op(input int grp, input port_t port, input logic wr,
                                   input addr_t addr, input size_t size, input strb_t strb,
                                   input word_t wdata);
        op_t op;
        op = '{grp[7:0], port, wr, addr, size, strb, wdata, 32'h0};
        ops.push_back(op);
    endfunction

    // byte-wise merge of writes in table order
    function automatic void compute_expected();
        addr_t b;
        for (int k = 0; k < ops.size(); k++) begin
            for (int n = 0; n < 4; n++) begin
                b = {ops[k].addr[31:2], 2'b00} + addr_t'(n);
                if (ops[k].wr && ops[k].strb[n]) begin
                    ref_mem[b] = ops[k].wdata[8*n +: 8];
                end else if (!ops[k].wr) begin
                    ops[k].exp[8*n +: 8] = ref_mem.exists(b) ? ref_mem[b] : expected_fill(b);
                end
            end
        end
    endfunction

    function automatic void build_table();
        add_op(0, 1, 1, 32'h100, 2, 4'hf, 32'h11223344);
        add_op(1, 1, 0, 32'h100, 2, 4'h0, 32'h0);
        add_op(2, 1, 1, 32'h102, 0, 4'b0100, 32'h00ab0000);
        add_op(3, 1, 0, 32'h100, 2, 4'h0, 32'h0);
        add_op(4, 0, 0, 32'h200, 2, 4'h0, 32'h0);
        add_op(4, 1, 0, 32'h300, 2, 4'h0, 32'h0);
        // read of the word being written on the other port
        add_op(5, 1, 1, 32'h240, 2, 4'hf, 32'hcafef00d);
        add_op(5, 0, 0, 32'h240, 2, 4'h0, 32'h0);
        add_op(6, 1, 1, 32'h104, 1, 4'b0011, 32'h0000beef);
        add_op(6, 0, 0, 32'h100, 2, 4'h0, 32'h0);
        add_op(7, 0, 0, 32'h104, 2, 4'h0, 32'h0);
        add_op(7, 1, 0, 32'h240, 2, 4'h0, 32'h0);
        add_op(8, 0, 1, 32'h400, 2, 4'hf, 32'h0badcafe);
        add_op(8, 1, 0, 32'h500, 2, 4'h0, 32'h0);
        add_op(9, 1, 0, 32'h400, 2, 4'h0, 32'h0);
        add_op(9, 0, 0, 32'h300, 2, 4'h0, 32'h0);
        // random traffic with each port in its own region
        for (int g = 10; g < 22; g++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                add_op(g, port_t'(p), logic'($urandom_range(0, 1)),
                       addr_t'(32'h600 + 32'h100 * p + 4 * $urandom_range(0, 7)), 2,
                       strb_t'($urandom_range(1, 15)), word_t'($urandom()));
            end
        end
    endfunction

    task automatic drive_port(input port_t p, input logic req, input op_t op);
        if (p) begin
            data_sram_req   = req;
            data_sram_wr    = op.wr;
            data_sram_size  = op.size;
            data_sram_addr  = op.addr;
            data_sram_wstrb = op.strb;
            data_sram_wdata = op.wdata;
        end else begin
            inst_sram_req   = req;
            inst_sram_wr    = op.wr;
            inst_sram_size  = op.size;
            inst_sram_addr  = op.addr;
            inst_sram_wstrb = op.strb;
            inst_sram_wdata = op.wdata;
        end
    endtask

    task automatic run_op(input int idx);
        op_t op;
        op = ops[idx];
        @(posedge clk);
        #2;
        cur_idx[op.port] = idx;
        drive_port(op.port, 1'b1, op);
        do @(negedge clk); while (!(op.port ? data_sram_addr_ok : inst_sram_addr_ok));
        // hold req one cycle past the take so the full slot is probed
        repeat (2) @(posedge clk);
        #2;
        drive_port(op.port, 1'b0, op);
        do @(negedge clk); while (!(op.port ? data_sram_data_ok : inst_sram_data_ok));
    endtask

    task automatic watch_port(input port_t p, input logic req, input logic addr_ok,
                              input logic data_ok, input word_t rd);
        op_t op;
        if (data_ok) begin
            if (open_cnt[p] == 0) begin
                $display("port %0d gave data_ok with no request open", p);
                stop_run();
            end
            op = ops[cur_idx[p]];
            if (op.wr) begin
                check_resp("bid", bid_prev, axi_id_t'(p));
                check_resp("wid", wid_prev, axi_id_t'(p));
            end else begin
                check_word(p ? "data_sram_rdata" : "inst_sram_rdata", rd, op.exp);
                check_id("rid", port_t'(rid_prev), p);
            end
            open_cnt[p]--;
        end
        if (req && addr_ok) begin
            if (open_cnt[p] != 0) begin
                $display("port %0d raised addr_ok with a request unanswered", p);
                stop_run();
            end
            open_cnt[p]++;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            watch_port(0, inst_sram_req, inst_sram_addr_ok, inst_sram_data_ok, inst_sram_rdata);
            watch_port(1, data_sram_req, data_sram_addr_ok, data_sram_data_ok, data_sram_rdata);
            if (arvalid && arready) begin
                audit_addr_beat("ar", 1'b0, arid, araddr, arsize, arlen, arburst, arlock,
                                arcache, arprot);
            end
            if (awvalid && awready) begin
                audit_addr_beat("aw", 1'b1, awid, awaddr, awsize, awlen, awburst, awlock,
                                awcache, awprot);
            end
            if (wvalid && wready) begin
                check_word("wdata", wdata, ops[cur_idx[wid[0]]].wdata);
                check_strb("wstrb", wstrb, ops[cur_idx[wid[0]]].strb);
                check_bit("wlast", wlast, 1'b1);
                wid_prev = wid;
            end
            // data_ok follows its beat by one cycle
            if (rvalid && rready) begin
                rid_prev = rid;
            end
            if (bvalid && bready) begin
                bid_prev = bid;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, a request never completed", cycles);
            stop_run();
        end
    end

    initial begin
        void'($urandom(32'ha6d3));
        reset = 1'b1;
        drive_port(0, 1'b0, '0);
        drive_port(1, 1'b0, '0);
        open_cnt = '{0, 0};
        cur_idx  = '{0, 0};
        build_table();
        compute_expected();
        limit = ops.size() * 20;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        // idle after reset
        repeat (3) begin
            @(negedge clk);
            check_bit("arvalid", arvalid, 1'b0);
            check_bit("awvalid", awvalid, 1'b0);
            check_bit("wvalid", wvalid, 1'b0);
            check_bit("rready", rready, 1'b0);
            check_bit("bready", bready, 1'b0);
            check_bit("inst_sram_addr_ok", inst_sram_addr_ok, 1'b0);
            check_bit("data_sram_addr_ok", data_sram_addr_ok, 1'b0);
            check_bit("inst_sram_data_ok", inst_sram_data_ok, 1'b0);
            check_bit("data_sram_data_ok", data_sram_data_ok, 1'b0);
        end
        i = 0;
        while (i < ops.size()) begin
            j = i;
            while (j + 1 < ops.size() && ops[j + 1].grp == ops[i].grp) begin
                j++;
            end
            if (j == i) begin
                run_op(i);
            end else begin
                fork
                    run_op(i);
                    run_op(j);
                join
            end
            i = j + 1;
        end
        repeat (4) @(posedge clk);
        if (open_cnt[0] == 0 && open_cnt[1] == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("requests left unanswered at the end of the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: dv/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model
    import bridge_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  axi_id_t arid,
    input  addr_t   araddr,
    input  logic    arvalid,
    output logic    arready,
    output axi_id_t rid,
    output word_t   rdata,
    output logic    rvalid,
    input  logic    rready,
    input  axi_id_t awid,
    input  addr_t   awaddr,
    input  logic    awvalid,
    output logic    awready,
    input  word_t   wdata,
    input  strb_t   wstrb,
    input  logic    wvalid,
    output logic    wready,
    output axi_id_t bid,
    output logic    bvalid,
    input  logic    bready
);
    typedef struct packed {
        axi_id_t id;
        addr_t   addr;
    } rd_ent_t;

    rd_ent_t    rd_q [$];
    logic [7:0] mem [addr_t];
    int         ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    int         pick;
    logic       aw_got, w_got;
    axi_id_t    aw_id_q;
    addr_t      aw_addr_q;
    word_t      w_data_q;
    strb_t      w_strb_q;
    logic       s_ar, s_r, s_aw, s_w, s_b;
    rd_ent_t    s_ar_ent;

    // unwritten bytes read back as a pattern of the whole address
    function automatic logic [7:0] fill_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hc3;
    endfunction

    function automatic word_t read_word(input addr_t a);
        word_t w;
        addr_t b;
        for (int i = 0; i < 4; i++) begin
            b = {a[31:2], 2'b00} + addr_t'(i);
            w[8*i +: 8] = mem.exists(b) ? mem[b] : fill_byte(b);
        end
        return w;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bid     = '0;
    end

    always begin
        // handshakes are settled by the negedge
        @(negedge clk);
        s_ar     = arvalid && arready;
        s_r      = rvalid && rready;
        s_aw     = awvalid && awready;
        s_w      = wvalid && wready;
        s_b      = bvalid && bready;
        s_ar_ent = '{arid, araddr};
        if (s_aw) begin
            aw_id_q   = awid;
            aw_addr_q = awaddr;
        end
        if (s_w) begin
            w_data_q = wdata;
            w_strb_q = wstrb;
        end
        @(posedge clk);
        #2;
        if (reset) begin
            rd_q.delete();
            {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} = '0;
            {aw_got, w_got} = 2'b00;
            {arready, rvalid, awready, wready, bvalid} = 5'b0;
        end else begin
            if (s_ar) begin
                rd_q.push_back(s_ar_ent);
                ar_cnt = int'($urandom_range(0, 3));
            end else if (ar_cnt > 0) begin
                ar_cnt--;
            end
            arready = (ar_cnt == 0);

            // any outstanding read may answer first
            if (s_r) begin
                rd_q.delete(pick);
                rvalid = 1'b0;
                r_cnt  = int'($urandom_range(0, 3));
            end else if (!rvalid && rd_q.size() > 0) begin
                if (r_cnt > 0) begin
                    r_cnt--;
                end else begin
                    pick   = int'($urandom_range(0, rd_q.size() - 1));
                    rvalid = 1'b1;
                    rid    = rd_q[pick].id;
                    rdata  = read_word(rd_q[pick].addr);
                end
            end

            if (s_aw) begin
                aw_got = 1'b1;
                aw_cnt = int'($urandom_range(0, 3));
            end else if (aw_cnt > 0) begin
                aw_cnt--;
            end
            if (s_w) begin
                w_got = 1'b1;
                w_cnt = int'($urandom_range(0, 3));
            end else if (w_cnt > 0) begin
                w_cnt--;
            end

            if (s_b) begin
                bvalid = 1'b0;
                aw_got = 1'b0;
                w_got  = 1'b0;
                b_cnt  = int'($urandom_range(0, 3));
            end else if (aw_got && w_got && !bvalid) begin
                if (b_cnt > 0) begin
                    b_cnt--;
                end else begin
                    for (int i = 0; i < 4; i++) begin
                        if (w_strb_q[i]) begin
                            mem[{aw_addr_q[31:2], 2'b00} + addr_t'(i)] = w_data_q[8*i +: 8];
                        end
                    end
                    bvalid = 1'b1;
                    bid    = aw_id_q;
                end
            end
            awready = (aw_cnt == 0) && !aw_got;
            wready  = (w_cnt == 0) && !w_got;
        end
    end

endmodule

`default_nettype wire

// File: logic/sram_axi_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module sram_axi_bridge
    import bridge_pkg::*;
(
    input  logic        clk,
    input  logic        reset,

    input  logic        inst_sram_req,
    input  logic        inst_sram_wr,
    input  logic [1:0]  inst_sram_size,
    input  logic [31:0] inst_sram_addr,
    input  logic [3:0]  inst_sram_wstrb,
    input  logic [31:0] inst_sram_wdata,
    output logic        inst_sram_addr_ok,
    output logic        inst_sram_data_ok,
    output logic [31:0] inst_sram_rdata,

    input  logic        data_sram_req,
    input  logic        data_sram_wr,
    input  logic [1:0]  data_sram_size,
    input  logic [31:0] data_sram_addr,
    input  logic [3:0]  data_sram_wstrb,
    input  logic [31:0] data_sram_wdata,
    output logic        data_sram_addr_ok,
    output logic        data_sram_data_ok,
    output logic [31:0] data_sram_rdata,

    output logic [3:0]  arid,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [2:0]  arsize,
    output logic [1:0]  arburst,
    output logic [1:0]  arlock,
    output logic [3:0]  arcache,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,

    input  logic [3:0]  rid,
    input  logic [31:0] rdata,
    input  logic        rvalid,
    output logic        rready,

    output logic [3:0]  awid,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [2:0]  awsize,
    output logic [1:0]  awburst,
    output logic [1:0]  awlock,
    output logic [3:0]  awcache,
    output logic [2:0]  awprot,
    output logic        awvalid,
    input  logic        awready,

    output logic [3:0]  wid,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,

    input  logic [3:0]  bid,
    input  logic        bvalid,
    output logic        bready
);
    logic [NUM_PORTS-1:0] pending;
    logic [NUM_PORTS-1:0] rd_issue;
    logic [NUM_PORTS-1:0] wr_issue;
    logic [NUM_PORTS-1:0] rd_busy;
    logic [NUM_PORTS-1:0] rd_done;
    logic [NUM_PORTS-1:0] wr_done;
    slot_req_t            held [NUM_PORTS];
    word_t                rd_data;
    logic                 wr_busy;
    addr_t                wr_addr;

    sram_if inst_bus ();
    sram_if data_bus ();

    assign inst_bus.req       = inst_sram_req;
    assign inst_bus.wr        = inst_sram_wr;
    assign inst_bus.size      = inst_sram_size;
    assign inst_bus.addr      = inst_sram_addr;
    assign inst_bus.wstrb     = inst_sram_wstrb;
    assign inst_bus.wdata     = inst_sram_wdata;
    assign inst_sram_addr_ok  = inst_bus.addr_ok;
    assign inst_sram_data_ok  = inst_bus.data_ok;
    assign inst_sram_rdata    = inst_bus.rdata;

    assign data_bus.req       = data_sram_req;
    assign data_bus.wr        = data_sram_wr;
    assign data_bus.size      = data_sram_size;
    assign data_bus.addr      = data_sram_addr;
    assign data_bus.wstrb     = data_sram_wstrb;
    assign data_bus.wdata     = data_sram_wdata;
    assign data_sram_addr_ok  = data_bus.addr_ok;
    assign data_sram_data_ok  = data_bus.data_ok;
    assign data_sram_rdata    = data_bus.rdata;

    // single-beat, unlocked, normal access
    assign arlen   = AXI_LEN_SINGLE;
    assign arburst = AXI_BURST_INCR;
    assign arlock  = 2'b00;
    assign arcache = 4'b0000;
    assign arprot  = 3'b000;
    assign awlen   = AXI_LEN_SINGLE;
    assign awburst = AXI_BURST_INCR;
    assign awlock  = 2'b00;
    assign awcache = 4'b0000;
    assign awprot  = 3'b000;
    assign wid     = awid;
    assign wlast   = 1'b1;

    sram_port_slot inst_slot (
        .clk     (clk),
        .reset   (reset),
        .port    (inst_bus),
        .pending (pending[0]),
        .held    (held[0]),
        .issue   (rd_issue[0] | wr_issue[0]),
        .rd_done (rd_done[0]),
        .wr_done (wr_done[0]),
        .rd_data (rd_data)
    );

    sram_port_slot data_slot (
        .clk     (clk),
        .reset   (reset),
        .port    (data_bus),
        .pending (pending[1]),
        .held    (held[1]),
        .issue   (rd_issue[1] | wr_issue[1]),
        .rd_done (rd_done[1]),
        .wr_done (wr_done[1]),
        .rd_data (rd_data)
    );

    bridge_arbiter arbiter (
        .clk      (clk),
        .reset    (reset),
        .pending  (pending),
        .held     (held),
        .rd_busy  (rd_busy),
        .wr_busy  (wr_busy),
        .wr_addr  (wr_addr),
        .rd_issue (rd_issue),
        .wr_issue (wr_issue)
    );

    axi_read_channel read_channel (
        .clk     (clk),
        .reset   (reset),
        .issue   (rd_issue),
        .held    (held),
        .arid    (arid),
        .araddr  (araddr),
        .arsize  (arsize),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_busy (rd_busy),
        .rd_done (rd_done),
        .rd_data (rd_data)
    );

    axi_write_channel write_channel (
        .clk     (clk),
        .reset   (reset),
        .issue   (wr_issue),
        .held    (held),
        .awid    (awid),
        .awaddr  (awaddr),
        .awsize  (awsize),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_busy (wr_busy),
        .wr_addr (wr_addr),
        .wr_done (wr_done)
    );

endmodule

`default_nettype wire

// File: logic/axi_write_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_channel
    import bridge_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] issue,
    input  slot_req_t            held [NUM_PORTS],
    output axi_id_t              awid,
    output addr_t                awaddr,
    output logic [2:0]           awsize,
    output logic                 awvalid,
    input  logic                 awready,
    output word_t                wdata,
    output strb_t                wstrb,
    output logic                 wvalid,
    input  logic                 wready,
    input  axi_id_t              bid,
    input  logic                 bvalid,
    output logic                 bready,
    output logic                 wr_busy,
    output addr_t                wr_addr,
    output logic [NUM_PORTS-1:0] wr_done
);
    logic  busy;
    port_t aw_port;
    logic  b_fire;
    logic  aw_left;
    logic  w_left;

    assign b_fire  = bvalid && bready;
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;
    assign awid    = axi_id_t'(aw_port);
    assign wr_busy = busy;
    assign wr_addr = awaddr;

    always_comb begin
        wr_done = '0;
        if (b_fire) begin
            wr_done[aw_port] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
        end else if (|issue) begin
            busy    <= 1'b1;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
            // B is taken once both AW and W are through
            if (b_fire) begin
                busy   <= 1'b0;
                bready <= 1'b0;
            end else if (busy && !bready && !aw_left && !w_left) begin
                bready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (issue[p]) begin
                awaddr  <= held[p].addr;
                awsize  <= {1'b0, held[p].size};
                wdata   <= held[p].data;
                wstrb   <= held[p].strb;
                aw_port <= port_t'(p);
            end
        end
    end

    a_wstrb_stable: assert property (
        @(posedge clk) disable iff (reset)
        w_left |=> $stable(wstrb)
    ) else $error("wstrb changed while W was waiting");

    a_bid_match: assert property (
        @(posedge clk) disable iff (reset)
        b_fire |-> bid == awid
    ) else $error("B response ID differs from the write in flight");

endmodule

`default_nettype wire

// File: logic/axi_read_channel.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_channel
    import bridge_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] issue,
    input  slot_req_t            held [NUM_PORTS],
    output axi_id_t              arid,
    output addr_t                araddr,
    output logic [2:0]           arsize,
    output logic                 arvalid,
    input  logic                 arready,
    input  axi_id_t              rid,
    input  word_t                rdata,
    input  logic                 rvalid,
    output logic                 rready,
    output logic [NUM_PORTS-1:0] rd_busy,
    output logic [NUM_PORTS-1:0] rd_done,
    output word_t                rd_data
);
    logic [NUM_PORTS-1:0] outstanding;
    port_t                ar_port;
    logic                 r_fire;

    assign r_fire  = rvalid && rready;
    assign rready  = |outstanding;
    assign arid    = axi_id_t'(ar_port);
    assign rd_data = rdata;
    // a held AR blocks both ports
    assign rd_busy = outstanding | {NUM_PORTS{arvalid}};

    always_comb begin
        rd_done = '0;
        if (r_fire) begin
            rd_done[port_t'(rid)] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arvalid     <= 1'b0;
            outstanding <= '0;
        end else begin
            if (|issue) begin
                arvalid <= 1'b1;
            end else if (arready) begin
                arvalid <= 1'b0;
            end
            outstanding <= (outstanding | issue) & ~rd_done;
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (issue[p]) begin
                araddr  <= held[p].addr;
                arsize  <= {1'b0, held[p].size};
                ar_port <= port_t'(p);
            end
        end
    end

    a_rid_known: assert property (
        @(posedge clk) disable iff (reset)
        r_fire |-> (rid < NUM_PORTS) && outstanding[port_t'(rid)]
    ) else $error("R beat for an ID with no read outstanding");

endmodule

`default_nettype wire

// File: logic/bridge_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module bridge_arbiter
    import bridge_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [NUM_PORTS-1:0] pending,
    input  slot_req_t            held [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] rd_busy,
    input  logic                 wr_busy,
    input  addr_t                wr_addr,
    output logic [NUM_PORTS-1:0] rd_issue,
    output logic [NUM_PORTS-1:0] wr_issue
);
    logic [NUM_PORTS-1:0] rd_want;
    logic [NUM_PORTS-1:0] wr_want;
    logic [NUM_PORTS-1:0] raw_block;
    addr_t                hold_addr;

    function automatic logic same_word(input addr_t a, input addr_t b);
        return a[31:2] == b[31:2];
    endfunction

    // higher port index wins the write grant
    always_comb begin
        wr_issue  = '0;
        hold_addr = wr_addr;
        for (int p = 0; p < NUM_PORTS; p++) begin
            wr_want[p] = pending[p] && held[p].wr && !wr_busy;
            if (wr_want[p]) begin
                wr_issue    = '0;
                wr_issue[p] = 1'b1;
                hold_addr   = held[p].addr;
            end
        end
    end

    // a read waits for any write to its word still short of B,
    // including one granted in this very cycle
    always_comb begin
        rd_issue = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            raw_block[p] = (wr_busy || (|wr_issue)) && same_word(held[p].addr, hold_addr);
            rd_want[p]   = pending[p] && !held[p].wr && !rd_busy[p] && !raw_block[p];
            if (rd_want[p]) begin
                rd_issue    = '0;
                rd_issue[p] = 1'b1;
            end
        end
    end

    // a granted request is no longer offered at the next edge
    a_grant_once: assert property (
        @(posedge clk) disable iff (reset)
        (|(rd_issue | wr_issue)) |=> ((pending & $past(rd_issue | wr_issue)) == '0)
    ) else $error("port granted twice for one request");

endmodule

`default_nettype wire

// File: logic/sram_port_slot.sv
`timescale 1ns/10ps
`default_nettype none

module sram_port_slot
    import bridge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    sram_if.slave     port,
    output logic      pending,
    output slot_req_t held,
    input  logic      issue,
    input  logic      rd_done,
    input  logic      wr_done,
    input  word_t     rd_data
);
    logic  valid;
    logic  issued;
    logic  data_ok_q;
    word_t rdata_q;
    logic  take;

    // slot frees itself in the data_ok cycle
    assign port.addr_ok = port.req && (!valid || data_ok_q);
    assign port.data_ok = data_ok_q;
    assign port.rdata   = rdata_q;

    assign take    = port.addr_ok;
    assign pending = valid && !issued;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid     <= 1'b0;
            issued    <= 1'b0;
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= rd_done || wr_done;
            if (take) begin
                valid  <= 1'b1;
                issued <= 1'b0;
            end else begin
                if (data_ok_q) begin
                    valid <= 1'b0;
                end
                if (issue) begin
                    issued <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            held.wr   <= port.wr;
            held.size <= port.size;
            held.addr <= port.addr;
            held.strb <= port.wstrb;
            held.data <= port.wdata;
        end
        // writes answer with zero
        if (rd_done || wr_done) begin
            rdata_q <= rd_done ? rd_data : '0;
        end
    end

    a_done_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        (rd_done || wr_done) |-> (valid && issued && !data_ok_q)
    ) else $error("done pulse without an issued request");

endmodule

`default_nettype wire

// File: logic/sram_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sram_if
    import bridge_pkg::*;
();
    logic  req;
    logic  wr;
    size_t size;
    addr_t addr;
    strb_t wstrb;
    word_t wdata;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;

    modport master (
        output req, wr, size, addr, wstrb, wdata,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, wr, size, addr, wstrb, wdata,
        output addr_ok, data_ok, rdata
    );
endinterface

`default_nettype wire

// File: logic/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    // log2 of the byte count
    typedef logic [1:0]  size_t;
    typedef logic [3:0]  axi_id_t;
    // 0 instruction, 1 data
    typedef logic        port_t;

    typedef struct packed {
        logic  wr;
        size_t size;
        addr_t addr;
        strb_t strb;
        word_t data;
    } slot_req_t;

    localparam int NUM_PORTS = 2;

    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

endpackage

`default_nettype wire
